//--- Bender.yml
package:
  name: lsu_subsys

sources:
  # Design, in compile order
  - design/lsu_pkg.sv
  - design/lsu_stream_reg.sv
  - design/lsu_id_table.sv
  - design/lsu_unit.sv
  - design/lsu_mem_bank.sv
  - design/lsu_subsys_top.sv
  # Testbench
  - target: simulation
    files:
      - verif/lsu_tb_clock.sv
      - verif/lsu_tb.sv

//--- design/lsu_id_table.sv
// Load ID allocator with per-ID metadata storage
`timescale 1ns/1ns
`default_nettype none

module lsu_id_table (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  // Allocation side
  input  wire logic                push_i,
  input  wire lsu_pkg::lsu_meta_t  push_meta_i,
  output lsu_pkg::meta_id_t        free_id_o,
  output logic                     full_o,
  // Release side
  input  wire logic                pop_i,
  input  wire lsu_pkg::meta_id_t   pop_id_i,
  output lsu_pkg::lsu_meta_t       pop_meta_o
);

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  // One bit per ID, set means free
  logic [lsu_pkg::NumOutstandingLoads-1:0] avail_q;
  // Metadata per ID
  lsu_pkg::lsu_meta_t meta_q [lsu_pkg::NumOutstandingLoads];

  // --------------------------------------------------
  // Free ID search
  // --------------------------------------------------
  // Zero-count from the low end, so the lowest free ID wins
  always_comb begin
    free_id_o = '0;
    for (int i = lsu_pkg::NumOutstandingLoads - 1; i >= 0; i--) begin
      if (avail_q[i]) begin
        free_id_o = lsu_pkg::meta_id_t'(i);
      end
    end
  end

  // No free bit left
  assign full_o = ~|avail_q;

  // --------------------------------------------------
  // Availability tracking
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      avail_q <= '1;
    end else begin
      // Claim offered ID
      if (push_i) begin
        avail_q[free_id_o] <= 1'b0;
      end
      // Release returned ID
      if (pop_i) begin
        avail_q[pop_id_i] <= 1'b1;
      end
    end
  end

  // Metadata written on claim
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      meta_q[free_id_o] <= push_meta_i;
    end
  end

  // Read back for the returning load
  assign pop_meta_o = meta_q[pop_id_i];

endmodule

`default_nettype wire

//--- design/lsu_mem_bank.sv
// Byte-strobed word memory with per-ID pending load slots answering out of order
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_bank (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Requests from the request stage
  input  wire lsu_pkg::mem_req_t  req_i,
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  // Responses to the response stage
  output lsu_pkg::mem_rsp_t       rsp_o,
  output logic                    rsp_valid_o,
  input  wire logic               rsp_ready_i
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  logic [31:0] mem_q [lsu_pkg::MemWords];

  // Pending load slots, indexed by ID
  logic [lsu_pkg::NumOutstandingLoads-1:0] slot_busy_q;
  logic [2:0]                              slot_cnt_q  [lsu_pkg::NumOutstandingLoads];
  logic [31:0]                             slot_data_q [lsu_pkg::NumOutstandingLoads];
  logic [lsu_pkg::NumOutstandingLoads-1:0] slot_err_q;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  logic [$clog2(lsu_pkg::MemWords)-1:0]    word_idx;
  logic                                    in_range;
  logic                                    store_en;
  logic                                    load_en;
  logic [31:0]                             rd_data;
  logic [lsu_pkg::NumOutstandingLoads-1:0] slot_ready;
  lsu_pkg::meta_id_t                       sel_id;
  logic                                    rsp_fire;

  // Slots are per ID, so nothing ever blocks
  assign req_ready_o = 1'b1;

  assign word_idx = req_i.addr[2 +: $clog2(lsu_pkg::MemWords)];
  assign in_range = req_i.addr < 32'(lsu_pkg::MemWords * 4);
  // Out-of-range stores just vanish
  assign store_en = req_valid_i & req_ready_o & req_i.write & in_range;
  assign load_en  = req_valid_i & req_ready_o & ~req_i.write;
  // Zero data for an out-of-range load
  assign rd_data  = in_range ? mem_q[word_idx] : 32'h0;

  // --------------------------------------------------
  // Word memory
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int w = 0; w < lsu_pkg::MemWords; w++) begin
        mem_q[w] <= '0;
      end
    end else if (store_en) begin
      // Write enabled lanes only
      for (int b = 0; b < 4; b++) begin
        if (req_i.strb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // Response selection
  // --------------------------------------------------
  // Slot is ready once its countdown hits zero
  always_comb begin
    for (int i = 0; i < lsu_pkg::NumOutstandingLoads; i++) begin
      slot_ready[i] = slot_busy_q[i] & (slot_cnt_q[i] == 3'd0);
    end
  end

  // Lowest ready slot first
  always_comb begin
    sel_id = '0;
    for (int i = lsu_pkg::NumOutstandingLoads - 1; i >= 0; i--) begin
      if (slot_ready[i]) begin
        sel_id = lsu_pkg::meta_id_t'(i);
      end
    end
  end

  assign rsp_valid_o = |slot_ready;
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;
  assign rsp_o.data  = slot_data_q[sel_id];
  assign rsp_o.error = slot_err_q[sel_id];
  assign rsp_o.id    = sel_id;

  // --------------------------------------------------
  // Slot control
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      slot_busy_q <= '0;
      for (int i = 0; i < lsu_pkg::NumOutstandingLoads; i++) begin
        slot_cnt_q[i] <= '0;
      end
    end else begin
      // Count down waiting slots
      for (int i = 0; i < lsu_pkg::NumOutstandingLoads; i++) begin
        if (slot_busy_q[i] && slot_cnt_q[i] != 3'd0) begin
          slot_cnt_q[i] <= slot_cnt_q[i] - 3'd1;
        end
      end
      if (rsp_fire) begin
        slot_busy_q[sel_id] <= 1'b0;
      end
      // Delay depends on address bits 3:2
      if (load_en) begin
        slot_busy_q[req_i.id] <= 1'b1;
        slot_cnt_q[req_i.id]  <= 3'd1 + {1'b0, req_i.addr[3:2]};
      end
    end
  end

  // Captured read data and error
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      slot_data_q[req_i.id] <= rd_data;
      slot_err_q[req_i.id]  <= ~in_range;
    end
  end

endmodule

`default_nettype wire

//--- design/lsu_pkg.sv
// Load-store subsystem sizes, tag and ID types, request, response and metadata structs
`default_nettype none

package lsu_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  // Loads in flight, must stay at least one
  localparam int unsigned NumOutstandingLoads = 4;
  // Width of a load ID
  localparam int unsigned IdWidth = $clog2(NumOutstandingLoads);
  // Memory depth in 32-bit words
  localparam int unsigned MemWords = 64;

  // --------------------------------------------------
  // Basic types
  // --------------------------------------------------
  typedef logic [4:0]         tag_t;
  typedef logic [IdWidth-1:0] meta_id_t;

  // Access size, fourth code reserved
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  // Core request
  typedef struct packed {
    tag_t        tag;
    logic        write;
    logic        is_signed;
    logic [31:0] addr;
    logic [31:0] data;
    lsu_size_e   size;
  } lsu_req_t;

  // Core response
  typedef struct packed {
    logic [31:0] data;
    tag_t        tag;
    logic        error;
  } lsu_rsp_t;

  // Word-aligned memory request
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] data;
    logic [3:0]  strb;
    meta_id_t    id;
  } mem_req_t;

  // Memory response, matched to its load by ID
  typedef struct packed {
    logic [31:0] data;
    logic        error;
    meta_id_t    id;
  } mem_rsp_t;

  // Per-load info kept until the response returns
  typedef struct packed {
    tag_t       tag;
    logic       sign_ext;
    logic [1:0] offset;
    lsu_size_e  size;
  } lsu_meta_t;

endpackage

`default_nettype wire

//--- design/lsu_stream_reg.sv
// Single-entry valid/ready pipeline register with a type-parameterized payload
`timescale 1ns/1ns
`default_nettype none

module lsu_stream_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  // Upstream side
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  // Downstream side
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  logic     full_q;
  payload_t data_q;
  logic     in_fire;

  // Take new item when empty or while the held one drains
  assign in_ready_o = ~full_q | out_ready_i;
  assign in_fire    = in_valid_i & in_ready_o;

  // Full flag
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload, only loaded on a transfer
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

endmodule

`default_nettype wire

//--- design/lsu_subsys_top.sv
// Load-store subsystem top with unit, request and response stages and memory bank
`timescale 1ns/1ns
`default_nettype none

module lsu_subsys_top (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Core request
  input  wire lsu_pkg::lsu_req_t  core_req_i,
  input  wire logic               core_req_valid_i,
  output logic                    core_req_ready_o,
  // Core response
  output lsu_pkg::lsu_rsp_t       core_rsp_o,
  output logic                    core_rsp_valid_o,
  input  wire logic               core_rsp_ready_i
);

  // Unit to request stage
  lsu_pkg::mem_req_t lsu_req;
  logic              lsu_req_valid;
  logic              lsu_req_ready;
  // Request stage to memory
  lsu_pkg::mem_req_t bank_req;
  logic              bank_req_valid;
  logic              bank_req_ready;
  // Memory to response stage
  lsu_pkg::mem_rsp_t bank_rsp;
  logic              bank_rsp_valid;
  logic              bank_rsp_ready;
  // Response stage to unit
  lsu_pkg::mem_rsp_t lsu_rsp;
  logic              lsu_rsp_valid;
  logic              lsu_rsp_ready;

  lsu_unit i_lsu_unit (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .core_req_i       ( core_req_i       ),
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_ready_o ( core_req_ready_o ),
    .core_rsp_o       ( core_rsp_o       ),
    .core_rsp_valid_o ( core_rsp_valid_o ),
    .core_rsp_ready_i ( core_rsp_ready_i ),
    .mem_req_o        ( lsu_req          ),
    .mem_req_valid_o  ( lsu_req_valid    ),
    .mem_req_ready_i  ( lsu_req_ready    ),
    .mem_rsp_i        ( lsu_rsp          ),
    .mem_rsp_valid_i  ( lsu_rsp_valid    ),
    .mem_rsp_ready_o  ( lsu_rsp_ready    )
  );

  // Outbound register stage
  lsu_stream_reg #(
    .payload_t ( lsu_pkg::mem_req_t )
  ) i_req_reg (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .in_valid_i  ( lsu_req_valid  ),
    .in_ready_o  ( lsu_req_ready  ),
    .in_data_i   ( lsu_req        ),
    .out_valid_o ( bank_req_valid ),
    .out_ready_i ( bank_req_ready ),
    .out_data_o  ( bank_req       )
  );

  lsu_mem_bank i_mem_bank (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .req_i       ( bank_req       ),
    .req_valid_i ( bank_req_valid ),
    .req_ready_o ( bank_req_ready ),
    .rsp_o       ( bank_rsp       ),
    .rsp_valid_o ( bank_rsp_valid ),
    .rsp_ready_i ( bank_rsp_ready )
  );

  // Return register stage
  lsu_stream_reg #(
    .payload_t ( lsu_pkg::mem_rsp_t )
  ) i_rsp_reg (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .in_valid_i  ( bank_rsp_valid ),
    .in_ready_o  ( bank_rsp_ready ),
    .in_data_i   ( bank_rsp       ),
    .out_valid_o ( lsu_rsp_valid  ),
    .out_ready_i ( lsu_rsp_ready  ),
    .out_data_o  ( lsu_rsp        )
  );

endmodule

`default_nettype wire

//--- design/lsu_unit.sv
// Load-store unit with request alignment, strobes, ID tagging and load data realignment
`timescale 1ns/1ns
`default_nettype none

module lsu_unit (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Core request
  input  wire lsu_pkg::lsu_req_t  core_req_i,
  input  wire logic               core_req_valid_i,
  output logic                    core_req_ready_o,
  // Core response
  output lsu_pkg::lsu_rsp_t       core_rsp_o,
  output logic                    core_rsp_valid_o,
  input  wire logic               core_rsp_ready_i,
  // Memory request
  output lsu_pkg::mem_req_t       mem_req_o,
  output logic                    mem_req_valid_o,
  input  wire logic               mem_req_ready_i,
  // Memory response
  input  wire lsu_pkg::mem_rsp_t  mem_rsp_i,
  input  wire logic               mem_rsp_valid_i,
  output logic                    mem_rsp_ready_o
);

  // --------------------------------------------------
  // Signals
  // --------------------------------------------------
  lsu_pkg::lsu_meta_t req_meta;
  lsu_pkg::lsu_meta_t rsp_meta;
  lsu_pkg::meta_id_t  free_id;
  logic               table_full;
  logic               table_push;
  logic               table_pop;
  logic               req_allowed;
  logic [1:0]         offset;
  logic [31:0]        shifted_data;
  logic [31:0]        ld_result;

  assign offset = core_req_i.addr[1:0];

  // --------------------------------------------------
  // ID table
  // --------------------------------------------------
  assign req_meta = '{
    tag:      core_req_i.tag,
    sign_ext: core_req_i.is_signed,
    offset:   offset,
    size:     core_req_i.size
  };

  lsu_id_table i_id_table (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .push_i      ( table_push  ),
    .push_meta_i ( req_meta    ),
    .free_id_o   ( free_id     ),
    .full_o      ( table_full  ),
    .pop_i       ( table_pop   ),
    .pop_id_i    ( mem_rsp_i.id ),
    .pop_meta_o  ( rsp_meta    )
  );

  // Claim ID when a load leaves, free it when its data goes to the core
  assign table_push = mem_req_valid_o & mem_req_ready_i & ~core_req_i.write;
  assign table_pop  = mem_rsp_valid_i & mem_rsp_ready_o;

  // --------------------------------------------------
  // Request path
  // --------------------------------------------------
  // Stores never wait on the table
  assign req_allowed      = core_req_i.write | ~table_full;
  assign mem_req_valid_o  = core_req_valid_i & req_allowed;
  assign core_req_ready_o = mem_req_ready_i & req_allowed;

  assign mem_req_o.addr  = {core_req_i.addr[31:2], 2'b00};
  assign mem_req_o.write = core_req_i.write;
  assign mem_req_o.id    = free_id;

  // Byte strobe from size and offset
  always_comb begin
    unique case (core_req_i.size)
      lsu_pkg::size_byte: mem_req_o.strb = 4'b0001 << offset;
      lsu_pkg::size_half: mem_req_o.strb = 4'b0011 << offset;
      lsu_pkg::size_word: mem_req_o.strb = 4'b1111;
      default:            mem_req_o.strb = 4'b0000;
    endcase
  end

  // Rotate store data into its lanes
  always_comb begin
    unique case (offset)
      2'd1:    mem_req_o.data = {core_req_i.data[23:0], core_req_i.data[31:24]};
      2'd2:    mem_req_o.data = {core_req_i.data[15:0], core_req_i.data[31:16]};
      2'd3:    mem_req_o.data = {core_req_i.data[7:0], core_req_i.data[31:8]};
      default: mem_req_o.data = core_req_i.data;
    endcase
  end

  // --------------------------------------------------
  // Response path
  // --------------------------------------------------
  // Move addressed byte down to lane 0
  assign shifted_data = mem_rsp_i.data >> {rsp_meta.offset, 3'b000};

  // Zero or sign extend by size
  always_comb begin
    unique case (rsp_meta.size)
      lsu_pkg::size_byte:
        ld_result = {{24{shifted_data[7] & rsp_meta.sign_ext}}, shifted_data[7:0]};
      lsu_pkg::size_half:
        ld_result = {{16{shifted_data[15] & rsp_meta.sign_ext}}, shifted_data[15:0]};
      default:
        ld_result = shifted_data;
    endcase
  end

  assign core_rsp_o.data  = ld_result;
  assign core_rsp_o.tag   = rsp_meta.tag;
  assign core_rsp_o.error = mem_rsp_i.error;

  // Straight handshake pass to the core
  assign core_rsp_valid_o = mem_rsp_valid_i;
  assign mem_rsp_ready_o  = core_rsp_ready_i;

endmodule

`default_nettype wire

//--- project.f
design/lsu_pkg.sv
design/lsu_stream_reg.sv
design/lsu_id_table.sv
design/lsu_unit.sv
design/lsu_mem_bank.sv
design/lsu_subsys_top.sv
verif/lsu_tb_clock.sv
verif/lsu_tb.sv

//--- verif/lsu_tb.sv
// Directed tests, byte-array memory model, response monitor, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

  localparam int unsigned MemBytes       = lsu_pkg::MemWords * 4;
  localparam int          HandshakeLimit = 60;
  // About 120 requests at up to ~12 cycles of 4 ns is ~6 us, so 20 us leaves margin
  localparam int          WatchdogNs     = 20000;

  logic              clk;
  logic              rst;
  lsu_pkg::lsu_req_t core_req;
  logic              core_req_valid;
  logic              core_req_ready;
  lsu_pkg::lsu_rsp_t core_rsp;
  logic              core_rsp_valid;
  logic              core_rsp_ready;

  // Byte-wide copy of the memory, updated on own stores
  logic [7:0]    ref_mem [MemBytes];
  // Response log per tag
  int            rsp_cnt [32];
  logic [31:0]   rsp_data [32];
  logic          rsp_err [32];
  logic          tag_is_load [32];
  lsu_pkg::tag_t next_tag;
  integer        seed;
  int            err_count;
  int            check_count;
  int            test_count;

  lsu_tb_clock i_clock (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  lsu_subsys_top dut (
    .clk_i            ( clk            ),
    .rst_i            ( rst            ),
    .core_req_i       ( core_req       ),
    .core_req_valid_i ( core_req_valid ),
    .core_req_ready_o ( core_req_ready ),
    .core_rsp_o       ( core_rsp       ),
    .core_rsp_valid_o ( core_rsp_valid ),
    .core_rsp_ready_i ( core_rsp_ready )
  );

  // --------------------------------------------------
  // Response monitor
  // --------------------------------------------------
  // Valid and ready are stable from the falling edge to the transfer edge
  always begin
    @(negedge clk);
    #1;
    if (!rst && core_rsp_valid && core_rsp_ready) begin
      rsp_cnt[core_rsp.tag]++;
      rsp_data[core_rsp.tag] = core_rsp.data;
      rsp_err[core_rsp.tag]  = core_rsp.error;
      // Stores must stay silent
      if (!tag_is_load[core_rsp.tag]) begin
        $display("ERROR at %0t ns: response for tag %0d which was no load", $time,
                 core_rsp.tag);
        err_count++;
      end
    end
  end

  // Watchdog
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired at %0t ns before all tests completed", $time);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic int size_bytes(input lsu_pkg::lsu_size_e size);
    case (size)
      lsu_pkg::size_byte: return 1;
      lsu_pkg::size_half: return 2;
      lsu_pkg::size_word: return 4;
      default:            return 0;
    endcase
  endfunction

  function automatic void ref_store(input logic [31:0] addr, input logic [31:0] data,
                                    input lsu_pkg::lsu_size_e size);
    int off;
    int base;
    off  = int'(addr[1:0]);
    base = int'(addr) - off;
    // Out-of-range stores are lost
    if (addr < MemBytes) begin
      for (int i = 0; i < size_bytes(size); i++) begin
        // Bytes past the word end have no lane
        if (off + i < 4) begin
          ref_mem[base + off + i] = data[8*i +: 8];
        end
      end
    end
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                           input lsu_pkg::lsu_size_e size,
                                           input logic sgn);
    logic [31:0] val;
    int          off;
    int          base;
    val  = '0;
    off  = int'(addr[1:0]);
    base = int'(addr) - off;
    if (addr < MemBytes) begin
      for (int i = 0; i < size_bytes(size); i++) begin
        if (off + i < 4) begin
          val[8*i +: 8] = ref_mem[base + off + i];
        end
      end
      // Sign fill above the loaded size
      if (sgn && size == lsu_pkg::size_byte && val[7]) begin
        val[31:8] = '1;
      end
      if (sgn && size == lsu_pkg::size_half && val[15]) begin
        val[31:16] = '1;
      end
    end
    return val;
  endfunction

  // --------------------------------------------------
  // Drivers and checks
  // --------------------------------------------------
  function automatic lsu_pkg::tag_t take_tag(input logic is_load);
    lsu_pkg::tag_t tag;
    tag              = next_tag;
    next_tag         = next_tag + 1'b1;
    rsp_cnt[tag]     = 0;
    tag_is_load[tag] = is_load;
    return tag;
  endfunction

  function automatic void set_req(input logic write, input logic sgn, input logic [31:0] addr,
                                  input logic [31:0] data, input lsu_pkg::lsu_size_e size,
                                  input lsu_pkg::tag_t tag);
    core_req.tag       = tag;
    core_req.write     = write;
    core_req.is_signed = sgn;
    core_req.addr      = addr;
    core_req.data      = data;
    core_req.size      = size;
  endfunction

  // Entered and left on a falling edge
  task automatic drive_req(input logic write, input logic sgn, input logic [31:0] addr,
                           input logic [31:0] data, input lsu_pkg::lsu_size_e size,
                           input lsu_pkg::tag_t tag);
    int waited;
    waited = 0;
    set_req(write, sgn, addr, data, size, tag);
    core_req_valid = 1'b1;
    #1;
    while (core_req_ready !== 1'b1 && waited < HandshakeLimit) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (core_req_ready !== 1'b1) begin
      $display("Request with tag %0d was not accepted within %0d cycles", tag, HandshakeLimit);
      err_count++;
    end
    // Transfer at the rising edge in between
    @(negedge clk);
    core_req_valid = 1'b0;
  endtask

  task automatic await_rsp(input lsu_pkg::tag_t tag);
    int waited;
    waited = 0;
    while (rsp_cnt[tag] == 0 && waited < HandshakeLimit) begin
      @(negedge clk);
      waited++;
    end
    if (rsp_cnt[tag] == 0) begin
      $display("No response for tag %0d arrived within %0d cycles", tag, HandshakeLimit);
      err_count++;
    end
  endtask

  task automatic check_rsp(input lsu_pkg::tag_t tag, input logic [31:0] exp_data,
                           input logic exp_err);
    check_count++;
    if (rsp_cnt[tag] != 1) begin
      $display("ERROR at %0t ns: tag %0d answered %0d times", $time, tag, rsp_cnt[tag]);
      err_count++;
    end else if (rsp_data[tag] !== exp_data || rsp_err[tag] !== exp_err) begin
      $display("ERROR at %0t ns: tag %0d got %h err %b, expected %h err %b", $time, tag,
               rsp_data[tag], rsp_err[tag], exp_data, exp_err);
      err_count++;
    end
  endtask

  task automatic run_store(input logic [31:0] addr, input logic [31:0] data,
                           input lsu_pkg::lsu_size_e size);
    lsu_pkg::tag_t tag;
    tag = take_tag(1'b0);
    ref_store(addr, data, size);
    drive_req(1'b1, 1'b0, addr, data, size, tag);
  endtask

  task automatic run_load(input logic [31:0] addr, input lsu_pkg::lsu_size_e size,
                          input logic sgn);
    lsu_pkg::tag_t tag;
    logic [31:0]   exp;
    tag = take_tag(1'b1);
    exp = ref_load(addr, size, sgn);
    drive_req(1'b0, sgn, addr, 32'h0, size, tag);
    await_rsp(tag);
    check_rsp(tag, exp, addr >= MemBytes);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("%-20s finished with %0d errors", name, err_count - errs_before);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic word_store_load();
    int          errs_before;
    logic [31:0] addrs [5] = '{32'h00, 32'h04, 32'h40, 32'h88, 32'hFC};
    errs_before = err_count;
    // Idle state after reset
    check_count++;
    if (core_rsp_valid !== 1'b0 || core_req_ready !== 1'b1) begin
      $display("ERROR at %0t ns: not idle after reset", $time);
      err_count++;
    end
    for (int i = 0; i < 5; i++) begin
      run_store(addrs[i], $random(seed), lsu_pkg::size_word);
    end
    for (int i = 0; i < 5; i++) begin
      run_load(addrs[i], lsu_pkg::size_word, 1'b0);
    end
    report_test("word_store_load", errs_before);
  endtask

  task automatic subword_lanes();
    int          errs_before;
    logic [31:0] data;
    errs_before = err_count;
    for (int o = 0; o < 4; o++) begin
      // Byte at offset o, sign bit alternating
      data    = $random(seed);
      data[7] = o[0];
      run_store(32'h20, $random(seed), lsu_pkg::size_word);
      run_store(32'h20 + o, data, lsu_pkg::size_byte);
      run_load(32'h20, lsu_pkg::size_word, 1'b0);
      run_load(32'h20 + o, lsu_pkg::size_byte, 1'b0);
      run_load(32'h20 + o, lsu_pkg::size_byte, 1'b1);
      // Half-word at offset o
      data     = $random(seed);
      data[15] = ~o[0];
      run_store(32'h30, $random(seed), lsu_pkg::size_word);
      run_store(32'h30 + o, data, lsu_pkg::size_half);
      run_load(32'h30, lsu_pkg::size_word, 1'b0);
      run_load(32'h30 + o, lsu_pkg::size_half, 1'b0);
      run_load(32'h30 + o, lsu_pkg::size_half, 1'b1);
    end
    report_test("subword_lanes", errs_before);
  endtask

  task automatic out_of_order_return();
    int            errs_before;
    // Delays 4, 1, 3, 2 from address bits 3:2
    logic [31:0]   addrs [4] = '{32'h0C, 32'h10, 32'h28, 32'h34};
    lsu_pkg::tag_t tags [4];
    logic [31:0]   exp [4];
    errs_before = err_count;
    for (int i = 0; i < 4; i++) begin
      run_store(addrs[i], $random(seed), lsu_pkg::size_word);
    end
    for (int i = 0; i < 4; i++) begin
      tags[i] = take_tag(1'b1);
      exp[i]  = ref_load(addrs[i], lsu_pkg::size_word, 1'b0);
    end
    // Back to back, one per cycle
    for (int i = 0; i < 4; i++) begin
      drive_req(1'b0, 1'b0, addrs[i], 32'h0, lsu_pkg::size_word, tags[i]);
    end
    for (int i = 0; i < 4; i++) begin
      await_rsp(tags[i]);
      check_rsp(tags[i], exp[i], 1'b0);
    end
    report_test("out_of_order_return", errs_before);
  endtask

  task automatic backpressure_hold();
    int            errs_before;
    lsu_pkg::tag_t tags [6];
    logic [31:0]   exp [6];
    errs_before = err_count;
    // Distinct data so a swapped tag shows
    for (int i = 0; i < 6; i++) begin
      run_store(32'(4 * i), $random(seed), lsu_pkg::size_word);
    end
    core_rsp_ready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      tags[i] = take_tag(1'b1);
      exp[i]  = ref_load(32'(4 * i), lsu_pkg::size_word, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      drive_req(1'b0, 1'b0, 32'(4 * i), 32'h0, lsu_pkg::size_word, tags[i]);
    end
    // Fifth load must wait on a full ID table
    set_req(1'b0, 1'b0, 32'd16, 32'h0, lsu_pkg::size_word, tags[4]);
    core_req_valid = 1'b1;
    for (int c = 0; c < 10; c++) begin
      #1;
      check_count++;
      if (core_req_ready !== 1'b0) begin
        $display("ERROR at %0t ns: request ready high with four loads outstanding", $time);
        err_count++;
      end
      @(negedge clk);
    end
    core_rsp_ready = 1'b1;
    drive_req(1'b0, 1'b0, 32'd16, 32'h0, lsu_pkg::size_word, tags[4]);
    drive_req(1'b0, 1'b0, 32'd20, 32'h0, lsu_pkg::size_word, tags[5]);
    for (int i = 0; i < 6; i++) begin
      await_rsp(tags[i]);
    end
    // Extra idle time to catch duplicates
    repeat (10) @(negedge clk);
    for (int i = 0; i < 6; i++) begin
      check_rsp(tags[i], exp[i], 1'b0);
    end
    report_test("backpressure_hold", errs_before);
  endtask

  task automatic out_of_range_access();
    int errs_before;
    errs_before = err_count;
    run_load(MemBytes, lsu_pkg::size_word, 1'b0);
    run_load(32'h0000_1004, lsu_pkg::size_byte, 1'b1);
    run_load(32'hFFFF_FFFC, lsu_pkg::size_half, 1'b0);
    // Word index bits alias words 1 and 0
    run_store(MemBytes + 4, 32'hDEAD_BEEF, lsu_pkg::size_word);
    run_store(32'h0000_0400, 32'hCAFE_F00D, lsu_pkg::size_word);
    run_load(32'h4, lsu_pkg::size_word, 1'b0);
    run_load(32'h0, lsu_pkg::size_word, 1'b0);
    report_test("out_of_range_access", errs_before);
  endtask

  task automatic random_mix();
    int                 errs_before;
    logic [31:0]        rnd;
    logic [31:0]        addr;
    lsu_pkg::lsu_size_e size;
    errs_before = err_count;
    for (int n = 0; n < 40; n++) begin
      rnd  = $random(seed);
      size = lsu_pkg::lsu_size_e'($unsigned($random(seed)) % 3);
      // First 16 words, so loads often hit stored data
      addr = ($unsigned($random(seed)) % 16) * 4;
      if (size != lsu_pkg::size_word) begin
        addr[1:0] = rnd[2:1];
      end
      if (rnd[0]) begin
        run_store(addr, $random(seed), size);
      end else begin
        run_load(addr, size, rnd[3]);
      end
    end
    report_test("random_mix", errs_before);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    seed           = 32'h6031;
    err_count      = 0;
    check_count    = 0;
    test_count     = 0;
    next_tag       = '0;
    core_req       = '0;
    core_req_valid = 1'b0;
    core_rsp_ready = 1'b1;
    for (int i = 0; i < MemBytes; i++) begin
      ref_mem[i] = 8'h00;
    end
    for (int i = 0; i < 32; i++) begin
      rsp_cnt[i]     = 0;
      tag_is_load[i] = 1'b0;
    end
    @(negedge rst);
    @(negedge clk);
    word_store_load();
    subword_lanes();
    out_of_order_return();
    backpressure_hold();
    out_of_range_access();
    random_mix();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/lsu_tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module lsu_tb_clock (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  localparam int HalfPeriodNs = 2;
  localparam int ResetCycles  = 8;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriodNs clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire
